// File: test/lcdCalc_testdata.txt
// Per record, hex words: A signA B signB op(0 add, 1 sub, 2 mul, F end) resultNeg resultMag
// Signs are 1 for negative; the record with op F ends the list
0C 1 C8 0 0 0 00BC
05 0 09 0 1 1 0004
FF 0 FF 1 2 1 FE01
00 0 25 1 2 0 0000
64 1 64 1 1 0 0000
FF 1 FF 1 0 1 01FE
7B 0 2D 1 1 0 00A8
07 1 09 1 2 0 003F
C8 0 0D 0 1 0 00BB
FF 1 01 0 2 1 00FF
00 0 00 0 0 0 0000
63 0 63 1 0 0 0000
00 0 00 0 F 0 0000

// File: vlog.f
hw/calcPkg.sv
hw/lcdPkg.sv
hw/keyEdge.sv
hw/signedAlu.sv
hw/decimalDigits.sv
hw/lcdWriter.sv
hw/displaySequencer.sv
hw/lcdCalcTop.sv
test/clockGen.sv
test/lcdCalc_sva.sv
test/lcdCalcTb.sv

// File: run.sh
#!/bin/sh
# Builds and runs the testbench with Verilator; exit status is nonzero on failure
cd "$(dirname "$0")" && \
verilator --binary --timing --assert --timescale 1ns/100ps --top-module lcdCalcTb \
	-f vlog.f -Mdir obj_dir -o simv && \
./obj_dir/simv || exit 1

// File: test/lcdCalcTb.sv
// Run from the project root; vectors are read from test/lcdCalc_testdata.txt
`default_nettype none

module lcdCalcTb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int PowerUpCycles = 40;
	localparam int StepCycles = 3;
	localparam int PulseCycles = 2;
	localparam int ResetCycles = 10;
	localparam int MarginCycles = 2000;
	localparam int MaxVectors = 32;
	localparam int RecordWords = 7;
	localparam int SettleCycles = StepCycles + PulseCycles + 8; // Longer than one byte write

	logic clk;
	logic flag_rst;
	calcPkg::operand_t operandA;
	calcPkg::operand_t operandB;
	logic signA;
	logic signB;
	logic keyAdd;
	logic keySub;
	logic keyMul;
	logic keyEquals;
	logic lcdEn;
	logic lcdRs;
	lcdPkg::lcdByte_t lcdData;

	logic [15:0] testData [0:MaxVectors*RecordWords-1];
	logic capRs[$];
	lcdPkg::lcdByte_t capData[$];
	logic enPrev = 1'b0;
	logic pulseSeen = 1'b0;
	int sinceReset = 0;
	int cycleCount = 0;
	int cycleLimit = 100000; // Replaced once the vectors are counted

	clockGen #(.HalfPeriod(50), .ResetCycles(ResetCycles)) clocks (
		.clk(clk), .flag_rst(flag_rst)
	);

	lcdCalcTop #(
		.PowerUpCycles(PowerUpCycles), .StepCycles(StepCycles), .PulseCycles(PulseCycles)
	) DUT (
		.clk(clk), .flag_rst(flag_rst),
		.operandA(operandA), .operandB(operandB), .signA(signA), .signB(signB),
		.keyAdd(keyAdd), .keySub(keySub), .keyMul(keyMul), .keyEquals(keyEquals),
		.lcdEn(lcdEn), .lcdRs(lcdRs), .lcdData(lcdData)
	);

	bind lcdWriter lcdCalc_sva #(.PulseCycles(PulseCycles)) pinChecks (
		.clk(clk), .flag_rst(flag_rst), .byteStrobe(byteStrobe), .byteDone(byteDone),
		.lcdEn(lcdEn), .lcdRs(lcdRs), .lcdData(lcdData)
	);

	task automatic stopWithFailure(input string reason);
		$display("%s", reason);
		$display("*** FAILED ***");
		$fatal(1, "Run stopped on the first error");
	endtask

	task automatic reportMismatch(input string msg);
		stopWithFailure($sformatf("MISMATCH at %0d ns: %s", $time, msg));
	endtask

	// The display latches a byte when enable falls
	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount > cycleLimit) begin
			stopWithFailure($sformatf("Timeout: test did not finish within %0d cycles",
				cycleLimit));
		end
		if (flag_rst) begin
			sinceReset = 0;
			enPrev = 1'b0;
		end else begin
			sinceReset++;
			if (lcdEn && !enPrev && !pulseSeen) begin
				pulseSeen = 1'b1;
				if (sinceReset < PowerUpCycles) begin
					stopWithFailure($sformatf("First enable pulse came %0d cycles after reset",
						sinceReset));
				end
			end
			if (!lcdEn && enPrev) begin
				capRs.push_back(lcdRs);
				capData.push_back(lcdData);
			end
			enPrev = lcdEn;
		end
	end

	task automatic waitForBytes(input int count);
		while (capData.size() < count) @(posedge clk);
	endtask

	task automatic expectQuiet(input string when);
		repeat (SettleCycles) @(posedge clk);
		if (capData.size() != 0) begin
			stopWithFailure($sformatf("LCD received %0d unexpected bytes %s",
				capData.size(), when));
		end
	endtask

	task automatic takeByte(output logic rs, output lcdPkg::lcdByte_t data);
		if (capData.size() == 0) begin
			stopWithFailure("A byte was checked before the LCD received it");
		end
		rs = capRs.pop_front();
		data = capData.pop_front();
	endtask

	task automatic checkCommand(input lcdPkg::lcdByte_t expected, input string what);
		logic rs;
		lcdPkg::lcdByte_t data;
		takeByte(rs, data);
		if (rs !== 1'b0 || data !== expected) begin
			reportMismatch($sformatf("%s: expected command %02h, got rs=%0b data=%02h",
				what, expected, rs, data));
		end
	endtask

	task automatic checkChar(input lcdPkg::lcdByte_t expected, input string what);
		logic rs;
		lcdPkg::lcdByte_t data;
		takeByte(rs, data);
		if (rs !== 1'b1 || data !== expected) begin
			reportMismatch($sformatf("%s: expected char %02h, got rs=%0b data=%02h",
				what, expected, rs, data));
		end
	endtask

	// A minus is optional, so peek before taking it
	task automatic checkSign(input logic expected, input string what);
		logic gotMinus;
		if (capData.size() == 0) begin
			stopWithFailure("Sign position was checked before the LCD received it");
		end
		gotMinus = (capRs[0] === 1'b1) && (capData[0] === lcdPkg::CharMinus);
		if (gotMinus !== expected) begin
			reportMismatch($sformatf("%s: expected minus=%0b, got minus=%0b",
				what, expected, gotMinus));
		end
		if (gotMinus) begin
			void'(capRs.pop_front());
			void'(capData.pop_front());
		end
	endtask

	task automatic checkNumber(input int value, input int count, input string what);
		int place;
		int digit;
		for (place = count - 1; place >= 0; place--) begin
			digit = (value / (10 ** place)) % 10;
			checkChar(lcdPkg::CharZero + lcdPkg::lcdByte_t'(digit),
				$sformatf("%s digit %0d", what, count - place));
		end
	endtask

	task automatic pressOpKey(input calcPkg::opCode_t op);
		@(posedge clk);
		keyAdd <= (op == calcPkg::opAdd);
		keySub <= (op == calcPkg::opSub);
		keyMul <= (op == calcPkg::opMul);
		repeat (2) @(posedge clk);
		keyAdd <= 1'b0;
		keySub <= 1'b0;
		keyMul <= 1'b0;
	endtask

	task automatic pressEquals();
		@(posedge clk);
		keyEquals <= 1'b1;
		repeat (2) @(posedge clk);
		keyEquals <= 1'b0;
	endtask

	function automatic lcdPkg::lcdByte_t operatorChar(input calcPkg::opCode_t op);
		case (op)
			calcPkg::opAdd: return lcdPkg::CharPlus;
			calcPkg::opSub: return lcdPkg::CharMinus;
			default: return lcdPkg::CharTimes;
		endcase
	endfunction

	initial begin
		int vectorCount;
		int base;
		int aVal;
		int bVal;
		int result;
		int expMag;
		int digitCount;
		logic expNeg;
		logic [15:0] opWord;
		calcPkg::operand_t a;
		calcPkg::operand_t b;
		logic sa;
		logic sb;
		calcPkg::opCode_t op;

		operandA = '0;
		operandB = '0;
		signA = 1'b0;
		signB = 1'b0;
		keyAdd = 1'b0;
		keySub = 1'b0;
		keyMul = 1'b0;
		keyEquals = 1'b0;

		$readmemh("test/lcdCalc_testdata.txt", testData);
		vectorCount = 0;
		while (testData[vectorCount*RecordWords+4] !== 16'hF) begin
			if ($isunknown(testData[vectorCount*RecordWords+4]) || vectorCount == MaxVectors - 1) begin
				stopWithFailure("Test data file is missing or has no end record");
			end
			vectorCount++;
		end
		if (vectorCount == 0) begin
			stopWithFailure("Test data file holds no vectors");
		end
		cycleLimit = ResetCycles + PowerUpCycles
			+ vectorCount * 24 * (StepCycles + PulseCycles + 2) + MarginCycles;

		@(posedge clk);
		while (flag_rst) @(posedge clk);

		waitForBytes(4);
		checkCommand(lcdPkg::CmdFunctionSet, "init byte 1");
		checkCommand(lcdPkg::CmdDisplayOn, "init byte 2");
		checkCommand(lcdPkg::CmdClear, "init byte 3");
		checkCommand(lcdPkg::CmdEntryMode, "init byte 4");
		expectQuiet("after initialisation");

		pressEquals(); // No operation yet, so nothing is written
		expectQuiet("after equals without an operation");

		for (int v = 0; v < vectorCount; v++) begin
			base = v * RecordWords;
			a = testData[base][7:0];
			sa = testData[base+1][0];
			b = testData[base+2][7:0];
			sb = testData[base+3][0];
			opWord = testData[base+4];
			expNeg = testData[base+5][0];
			expMag = int'(testData[base+6]);
			if (opWord > 16'd2) begin
				stopWithFailure($sformatf("Test vector %0d has an unknown operation", v));
			end
			op = calcPkg::opCode_t'(opWord[1:0]);

			aVal = sa ? -int'(a) : int'(a);
			bVal = sb ? -int'(b) : int'(b);
			case (op)
				calcPkg::opAdd: result = aVal + bVal;
				calcPkg::opSub: result = aVal - bVal;
				default: result = aVal * bVal;
			endcase
			if ((result < 0) != expNeg || (result < 0 ? -result : result) != expMag) begin
				stopWithFailure($sformatf("Test vector %0d disagrees with its own arithmetic", v));
			end

			@(posedge clk);
			operandA <= a;
			operandB <= b;
			signA <= sa;
			signB <= sb;
			pressOpKey(op);
			waitForBytes(1);
			pressEquals(); // Arrives mid-line and must be dropped
			waitForBytes(10 + int'(sa) + int'(sb));
			checkCommand(lcdPkg::CmdClear, $sformatf("vector %0d line 1 clear", v));
			checkSign(sa, $sformatf("vector %0d A sign", v));
			checkNumber(int'(a), calcPkg::OperandDigits, $sformatf("vector %0d A", v));
			checkChar(lcdPkg::CharSpace, $sformatf("vector %0d space before operator", v));
			checkChar(operatorChar(op), $sformatf("vector %0d operator", v));
			checkChar(lcdPkg::CharSpace, $sformatf("vector %0d space after operator", v));
			checkSign(sb, $sformatf("vector %0d B sign", v));
			checkNumber(int'(b), calcPkg::OperandDigits, $sformatf("vector %0d B", v));
			expectQuiet($sformatf("after line 1 of vector %0d", v));

			digitCount = (op == calcPkg::opMul) ? calcPkg::ProductDigits : calcPkg::SumDigits;
			pressEquals();
			waitForBytes(1);
			pressOpKey(op); // Same inputs again, ignored while line 2 is written
			waitForBytes(1 + int'(expNeg) + digitCount);
			checkCommand(lcdPkg::CmdLine2, $sformatf("vector %0d line 2 address", v));
			checkSign(expNeg, $sformatf("vector %0d result sign", v));
			checkNumber(expMag, digitCount, $sformatf("vector %0d result", v));
			expectQuiet($sformatf("after line 2 of vector %0d", v));
		end

		repeat (SettleCycles) @(posedge clk);
		if (capData.size() != 0) begin
			stopWithFailure("LCD received bytes after the last vector");
		end else begin
			$display("*** PASSED ***");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: test/lcdCalc_sva.sv
// Bound to lcdWriter; PulseCycles must equal the writer's own setting
`default_nettype none

module lcdCalc_sva #(
	parameter int PulseCycles = 2
) (
	input logic clk,
	input logic flag_rst,
	input logic byteStrobe,
	input logic byteDone,
	input logic lcdEn,
	input logic lcdRs,
	input lcdPkg::lcdByte_t lcdData
);
	timeunit 1ns;
	timeprecision 100ps;

	int highCount; // Consecutive cycles with the enable high
	logic busy;

	always_ff @(posedge clk) begin
		if (flag_rst) begin
			highCount <= 0;
			busy <= 1'b0;
		end else begin
			highCount <= lcdEn ? highCount + 1 : 0;
			if (byteStrobe) begin
				busy <= 1'b1;
			end else if (byteDone) begin
				busy <= 1'b0;
			end
		end
	end

	pulseLength: assert property (@(posedge clk) disable iff (flag_rst)
		$fell(lcdEn) |-> highCount == PulseCycles)
		else $error("Enable pulse lasted %0d cycles", highCount);

	pinsStable: assert property (@(posedge clk) disable iff (flag_rst)
		lcdEn |-> $stable(lcdRs) && $stable(lcdData))
		else $error("rs or data changed while enable was high");

	enableLowInReset: assert property (@(posedge clk)
		flag_rst && $past(flag_rst) |-> !lcdEn)
		else $error("Enable high during reset");

	strobeWhenIdle: assert property (@(posedge clk) disable iff (flag_rst)
		byteStrobe |-> !busy)
		else $error("Byte strobe while the writer was busy");

endmodule

`default_nettype wire

// File: test/clockGen.sv
// Free-running testbench clock with a synchronous reset pulse released on a rising edge
`default_nettype none

module clockGen #(
	parameter int HalfPeriod = 50, // In ns, so a 100 ns period
	parameter int ResetCycles = 10
) (
	output logic clk,
	output logic flag_rst
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
		forever #HalfPeriod clk = ~clk;
	end

	initial begin
		flag_rst = 1'b1;
		repeat (ResetCycles) @(posedge clk);
		flag_rst <= 1'b0;
	end

endmodule

`default_nettype wire

// File: hw/lcdCalcTop.sv
// Defaults assume a 50 MHz clock; rw of the display is tied low on the board
`default_nettype none

module lcdCalcTop #(
	parameter int PowerUpCycles = 2250000, // 45 ms
	parameter int StepCycles = 250000, // 5 ms
	parameter int PulseCycles = 125000 // 2.5 ms
) (
	input logic clk,
	input logic flag_rst,
	input calcPkg::operand_t operandA,
	input calcPkg::operand_t operandB,
	input logic signA,
	input logic signB,
	input logic keyAdd,
	input logic keySub,
	input logic keyMul,
	input logic keyEquals,
	output logic lcdEn,
	output logic lcdRs,
	output lcdPkg::lcdByte_t lcdData
);

	logic addPress;
	logic subPress;
	logic mulPress;
	logic equalsPress;
	logic opPress;
	calcPkg::operand_t aMag;
	calcPkg::operand_t bMag;
	logic aNeg;
	logic bNeg;
	calcPkg::opCode_t op;
	calcPkg::result_t resultMag;
	logic resultNeg;
	calcPkg::digit_t [0:calcPkg::OperandDigits-1] aDigits;
	calcPkg::digit_t [0:calcPkg::OperandDigits-1] bDigits;
	calcPkg::digit_t [0:calcPkg::ProductDigits-1] resultDigits;
	logic byteStrobe;
	logic byteIsChar;
	logic byteDone;
	lcdPkg::lcdByte_t byteValue;

	assign opPress = addPress | subPress | mulPress;

	keyEdge keys (
		.clk(clk), .flag_rst(flag_rst),
		.keyAdd(keyAdd), .keySub(keySub), .keyMul(keyMul), .keyEquals(keyEquals),
		.addPress(addPress), .subPress(subPress), .mulPress(mulPress),
		.equalsPress(equalsPress)
	);

	signedAlu alu (
		.clk(clk), .flag_rst(flag_rst),
		.operandA(operandA), .operandB(operandB), .signA(signA), .signB(signB),
		.addPress(addPress), .subPress(subPress), .mulPress(mulPress),
		.aMag(aMag), .bMag(bMag), .aNeg(aNeg), .bNeg(bNeg), .op(op),
		.resultMag(resultMag), .resultNeg(resultNeg)
	);

	decimalDigits #(.Width(calcPkg::OperandWidth), .Digits(calcPkg::OperandDigits)) aConv (
		.value(aMag), .digits(aDigits)
	);

	decimalDigits #(.Width(calcPkg::OperandWidth), .Digits(calcPkg::OperandDigits)) bConv (
		.value(bMag), .digits(bDigits)
	);

	decimalDigits #(.Width(calcPkg::ResultWidth), .Digits(calcPkg::ProductDigits)) resultConv (
		.value(resultMag), .digits(resultDigits)
	);

	displaySequencer #(.PowerUpCycles(PowerUpCycles)) sequencer (
		.clk(clk), .flag_rst(flag_rst),
		.opPress(opPress), .equalsPress(equalsPress), .byteDone(byteDone),
		.aNeg(aNeg), .bNeg(bNeg), .resultNeg(resultNeg), .op(op),
		.aDigits(aDigits), .bDigits(bDigits), .resultDigits(resultDigits),
		.byteStrobe(byteStrobe), .byteIsChar(byteIsChar), .byteValue(byteValue)
	);

	lcdWriter #(.StepCycles(StepCycles), .PulseCycles(PulseCycles)) writer (
		.clk(clk), .flag_rst(flag_rst),
		.byteStrobe(byteStrobe), .byteIsChar(byteIsChar), .byteValue(byteValue),
		.byteDone(byteDone), .lcdEn(lcdEn), .lcdRs(lcdRs), .lcdData(lcdData)
	);

endmodule

`default_nettype wire

// File: hw/displaySequencer.sv
// Presses are dropped during power-up, init and any line write; equals needs an earlier operation
`default_nettype none

module displaySequencer #(
	parameter int PowerUpCycles = 2250000
) (
	input logic clk,
	input logic flag_rst,
	input logic opPress,
	input logic equalsPress,
	input logic byteDone,
	input logic aNeg,
	input logic bNeg,
	input logic resultNeg,
	input calcPkg::opCode_t op,
	input calcPkg::digit_t [0:calcPkg::OperandDigits-1] aDigits,
	input calcPkg::digit_t [0:calcPkg::OperandDigits-1] bDigits,
	input calcPkg::digit_t [0:calcPkg::ProductDigits-1] resultDigits,
	output logic byteStrobe,
	output logic byteIsChar,
	output lcdPkg::lcdByte_t byteValue
);

	localparam int PowerWidth = $clog2(PowerUpCycles + 1);
	localparam int OperandDigits = calcPkg::OperandDigits;

	// Line 1 holds clear, [-]AAA, space, op, space and [-]BBB
	localparam logic [3:0] PosADigit = 4'd2;
	localparam logic [3:0] PosOp = 4'(2 + OperandDigits + 1);
	localparam logic [3:0] PosBMinus = PosOp + 4'd2;
	localparam logic [3:0] PosBDigit = PosBMinus + 4'd1;
	localparam logic [3:0] Line1Last = 4'(PosBDigit + OperandDigits - 1);
	localparam logic [3:0] PosRDigit = 4'd2;

	typedef enum logic [1:0] {
		stPowerUp,
		stIssue,
		stWait,
		stIdle
	} state_t;

	typedef enum logic [1:0] {
		lineInit,
		line1,
		line2
	} line_t;

	state_t state;
	line_t line;
	logic [3:0] pos;
	logic [PowerWidth-1:0] powerCount;
	logic opSeen;
	logic entryValid; // Clear for a minus position that is skipped
	logic entryIsChar;
	logic entryLast;
	lcdPkg::lcdByte_t entryValue;
	lcdPkg::lcdByte_t opChar;
	logic [3:0] resultCount;
	logic [3:0] resultShift;

	function automatic lcdPkg::lcdByte_t charOf(input calcPkg::digit_t d);
		return lcdPkg::CharZero + {4'b0000, d};
	endfunction

	always_comb begin
		case (op)
			calcPkg::opAdd: opChar = lcdPkg::CharPlus;
			calcPkg::opSub: opChar = lcdPkg::CharMinus;
			default: opChar = lcdPkg::CharTimes;
		endcase
	end

	// Sums fit in three digits, so add and subtract drop the top two
	assign resultCount = (op == calcPkg::opMul)
		? 4'(calcPkg::ProductDigits) : 4'(calcPkg::SumDigits);
	assign resultShift = 4'(calcPkg::ProductDigits) - resultCount;

	always_comb begin
		entryValid = 1'b1;
		entryIsChar = 1'b1;
		entryValue = lcdPkg::CharSpace;
		entryLast = 1'b0;
		case (line)
			lineInit: begin
				entryIsChar = 1'b0;
				entryLast = (pos == 4'd3);
				case (pos)
					4'd0: entryValue = lcdPkg::CmdFunctionSet;
					4'd1: entryValue = lcdPkg::CmdDisplayOn;
					4'd2: entryValue = lcdPkg::CmdClear;
					default: entryValue = lcdPkg::CmdEntryMode;
				endcase
			end
			line1: begin
				entryLast = (pos == Line1Last);
				if (pos == 4'd0) begin
					entryIsChar = 1'b0;
					entryValue = lcdPkg::CmdClear;
				end else if (pos == 4'd1) begin
					entryValid = aNeg;
					entryValue = lcdPkg::CharMinus;
				end else if (pos == PosOp) begin
					entryValue = opChar;
				end else if (pos == PosBMinus) begin
					entryValid = bNeg;
					entryValue = lcdPkg::CharMinus;
				end
				for (int i = 0; i < OperandDigits; i++) begin
					if (pos == PosADigit + 4'(i)) begin
						entryValue = charOf(aDigits[i]);
					end
					if (pos == PosBDigit + 4'(i)) begin
						entryValue = charOf(bDigits[i]);
					end
				end
			end
			default: begin
				entryLast = (pos == resultCount + 4'd1);
				if (pos == 4'd0) begin
					entryIsChar = 1'b0;
					entryValue = lcdPkg::CmdLine2;
				end else if (pos == 4'd1) begin
					entryValid = resultNeg;
					entryValue = lcdPkg::CharMinus;
				end
				for (int i = 0; i < calcPkg::ProductDigits; i++) begin
					if (pos >= PosRDigit && pos + resultShift == PosRDigit + 4'(i)) begin
						entryValue = charOf(resultDigits[i]);
					end
				end
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (flag_rst) begin
			state <= stPowerUp;
			line <= lineInit;
			pos <= '0;
			powerCount <= '0;
			opSeen <= 1'b0;
			byteStrobe <= 1'b0;
			byteIsChar <= 1'b0;
			byteValue <= '0;
		end else begin
			byteStrobe <= 1'b0;
			case (state)
				stPowerUp: begin
					if (powerCount == PowerWidth'(PowerUpCycles - 1)) begin
						state <= stIssue;
					end else begin
						powerCount <= powerCount + 1'b1;
					end
				end
				stIssue: begin
					if (entryValid) begin
						byteStrobe <= 1'b1;
						byteIsChar <= entryIsChar;
						byteValue <= entryValue;
						state <= stWait;
					end else begin
						pos <= pos + 4'd1; // Skipped minus is never the last byte
					end
				end
				stWait: begin
					if (byteDone) begin
						if (entryLast) begin
							state <= stIdle;
						end else begin
							pos <= pos + 4'd1;
							state <= stIssue;
						end
					end
				end
				default: begin
					if (opPress) begin
						line <= line1;
						pos <= '0;
						opSeen <= 1'b1;
						state <= stIssue;
					end else if (equalsPress && opSeen) begin
						line <= line2;
						pos <= '0;
						state <= stIssue;
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hw/lcdWriter.sv
// StepCycles and PulseCycles must be at least 1; a strobe is only allowed while idle
`default_nettype none

module lcdWriter #(
	parameter int StepCycles = 250000,
	parameter int PulseCycles = 125000
) (
	input logic clk,
	input logic flag_rst,
	input logic byteStrobe,
	input logic byteIsChar,
	input lcdPkg::lcdByte_t byteValue,
	output logic byteDone,
	output logic lcdEn,
	output logic lcdRs,
	output lcdPkg::lcdByte_t lcdData
);

	localparam int MaxCycles = (StepCycles > PulseCycles) ? StepCycles : PulseCycles;
	localparam int CountWidth = $clog2(MaxCycles + 1);

	typedef enum logic [1:0] {
		stIdle,
		stSetup,
		stPulse
	} state_t;

	state_t state;
	logic [CountWidth-1:0] count;

	always_ff @(posedge clk) begin
		if (flag_rst) begin
			state <= stIdle;
			count <= '0;
			byteDone <= 1'b0;
			lcdEn <= 1'b0;
			lcdRs <= 1'b0;
			lcdData <= '0;
		end else begin
			byteDone <= 1'b0;
			case (state)
				stIdle: begin
					if (byteStrobe) begin
						lcdRs <= byteIsChar; // Held until the next strobe
						lcdData <= byteValue;
						count <= CountWidth'(StepCycles - 1);
						state <= stSetup;
					end
				end
				stSetup: begin
					if (count == '0) begin
						lcdEn <= 1'b1;
						count <= CountWidth'(PulseCycles - 1);
						state <= stPulse;
					end else begin
						count <= count - 1'b1;
					end
				end
				stPulse: begin
					if (count == '0) begin
						lcdEn <= 1'b0; // The display takes the byte on this edge
						byteDone <= 1'b1;
						state <= stIdle;
					end else begin
						count <= count - 1'b1;
					end
				end
				default: state <= stIdle;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hw/decimalDigits.sv
// Purely combinational; Digits must be large enough for the largest value of Width bits
`default_nettype none

module decimalDigits #(
	parameter int Width = 8,
	parameter int Digits = 3
) (
	input logic [Width-1:0] value,
	output calcPkg::digit_t [0:Digits-1] digits
);

	logic [Digits*4-1:0] bcd;

	// Shift-and-add-three, one pass per input bit from the top
	always_comb begin
		bcd = '0;
		for (int i = Width - 1; i >= 0; i--) begin
			for (int d = 0; d < Digits; d++) begin
				if (bcd[d*4 +: 4] > 4'd4) begin
					bcd[d*4 +: 4] = bcd[d*4 +: 4] + 4'd3;
				end
			end
			bcd = {bcd[Digits*4-2:0], value[i]};
		end
	end

	assign digits = bcd; // Element 0 lands on the top nibble

endmodule

`default_nettype wire

// File: hw/signedAlu.sv
// Latches on every operation strobe, also while the display is busy; results valid one cycle later
`default_nettype none

module signedAlu (
	input logic clk,
	input logic flag_rst,
	input calcPkg::operand_t operandA,
	input calcPkg::operand_t operandB,
	input logic signA,
	input logic signB,
	input logic addPress,
	input logic subPress,
	input logic mulPress,
	output calcPkg::operand_t aMag,
	output calcPkg::operand_t bMag,
	output logic aNeg,
	output logic bNeg,
	output calcPkg::opCode_t op,
	output calcPkg::result_t resultMag,
	output logic resultNeg
);

	localparam int CalcWidth = calcPkg::ResultWidth + 2; // Room for the sign of +-65025

	logic anyPress;
	logic signed [CalcWidth-1:0] aVal;
	logic signed [CalcWidth-1:0] bVal;
	logic signed [CalcWidth-1:0] resVal;

	assign anyPress = addPress | subPress | mulPress;

	always_ff @(posedge clk) begin
		if (anyPress) begin
			aMag <= operandA;
			bMag <= operandB;
			aNeg <= signA;
			bNeg <= signB;
		end
	end

	always_ff @(posedge clk) begin
		if (flag_rst) begin
			op <= calcPkg::opAdd;
		end else if (mulPress) begin
			op <= calcPkg::opMul;
		end else if (subPress) begin
			op <= calcPkg::opSub;
		end else if (addPress) begin
			op <= calcPkg::opAdd;
		end
	end

	always_comb begin
		aVal = CalcWidth'(aMag);
		bVal = CalcWidth'(bMag);
		if (aNeg) begin
			aVal = -aVal;
		end
		if (bNeg) begin
			bVal = -bVal;
		end
		case (op)
			calcPkg::opAdd: resVal = aVal + bVal;
			calcPkg::opSub: resVal = aVal - bVal;
			default: resVal = aVal * bVal;
		endcase
	end

	// A zero result has a clear sign bit, so -0 cannot occur
	assign resultNeg = resVal[CalcWidth-1];
	assign resultMag = calcPkg::result_t'(resultNeg ? -resVal : resVal);

endmodule

`default_nettype wire

// File: hw/keyEdge.sv
// Keys must be synchronous to clk; no debouncing, a key held through reset fires only after release
`default_nettype none

module keyEdge (
	input logic clk,
	input logic flag_rst,
	input logic keyAdd,
	input logic keySub,
	input logic keyMul,
	input logic keyEquals,
	output logic addPress,
	output logic subPress,
	output logic mulPress,
	output logic equalsPress
);

	logic [3:0] keys;
	logic [3:0] keyPrev;
	logic [3:0] armed; // Key has been seen low since reset
	logic [3:0] press;

	assign keys = {keyEquals, keyMul, keySub, keyAdd};

	always_ff @(posedge clk) begin
		if (flag_rst) begin
			keyPrev <= '0;
			armed <= '0;
			press <= '0;
		end else begin
			keyPrev <= keys;
			armed <= armed | ~keys;
			press <= armed & keys & ~keyPrev; // One cycle per rising edge
		end
	end

	assign addPress = press[0];
	assign subPress = press[1];
	assign mulPress = press[2];
	assign equalsPress = press[3];

endmodule

`default_nettype wire

// File: hw/lcdPkg.sv
// HD44780 bus word and codes for 8-bit mode, two-line display, no cursor
`default_nettype none

package lcdPkg;

	typedef logic [7:0] lcdByte_t;

	localparam lcdByte_t CmdFunctionSet = 8'h38; // 8-bit bus, two lines, 5x8 font
	localparam lcdByte_t CmdDisplayOn = 8'h0C;
	localparam lcdByte_t CmdClear = 8'h01;
	localparam lcdByte_t CmdEntryMode = 8'h06; // Cursor moves right, no shift
	localparam lcdByte_t CmdLine2 = 8'hC0;

	localparam lcdByte_t CharZero = 8'd48;
	localparam lcdByte_t CharMinus = 8'd45;
	localparam lcdByte_t CharPlus = 8'd43;
	localparam lcdByte_t CharTimes = 8'd42;
	localparam lcdByte_t CharSpace = 8'd32;

endpackage

`default_nettype wire

// File: hw/calcPkg.sv
// Arithmetic types for the calculator; magnitudes are unsigned, signs travel as separate flags
`default_nettype none

package calcPkg;

	localparam int OperandWidth = 8;
	localparam int ResultWidth = 16; // Holds 255 * 255
	localparam int OperandDigits = 3;
	localparam int ProductDigits = 5;
	localparam int SumDigits = 3; // Largest sum is 510

	typedef logic [OperandWidth-1:0] operand_t;
	typedef logic [ResultWidth-1:0] result_t;
	typedef logic [3:0] digit_t;

	typedef enum logic [1:0] {
		opAdd,
		opSub,
		opMul
	} opCode_t;

endpackage

`default_nettype wire
